// File: csi_pkg.sv
`default_nettype none

// ---------------------------------------------------------------------------
// shared constants and types for the two-lane csi receive path
// ---------------------------------------------------------------------------
package csi_pkg;

   // lane count
   localparam int NUM_LANES = 2;         // data lanes in this receiver

   // payload start marker as seen on the wire, lsb first
   localparam logic [7:0] SYNC_BYTE = 8'hB8;

   // line buffer geometry
   localparam int LANE_WORDS = 32;       // words owned by one lane
   localparam int BUF_AW     = 6;        // spans NUM_LANES * LANE_WORDS

   // one buffer word, first received byte sits in [7:0]
   typedef logic [15:0] buf_word_t;

endpackage

`default_nettype wire

// File: buf_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// one lane's write request into the shared line buffer
interface buf_wr_if
   import csi_pkg::*;
();

   logic              req;              // word pending, held until gnt
   logic              gnt;              // write happens in this cycle
   logic [BUF_AW-1:0] addr;             // stable while req waits
   buf_word_t         data;             // stable while req waits

   // lane writer side
   modport master  (output req, output addr, output data, input gnt);

   // arbiter side
   modport arbiter (input req, input addr, input data, output gnt);

endinterface

`default_nettype wire

// File: csi_rx_phy_dat.sv
`timescale 1ns/1ps
`default_nettype none

// behavioural stand-in for the lane input buffer and ddr deserializer
module csi_rx_phy_dat #(
   parameter logic INVERT = 1'b0        // set when the board swaps p and n
) (
   input  logic       bit_clock,        // ddr bit clock
   input  logic       byte_clock,       // bit_clock / 4
   input  logic       rst,              // raw reset, synced below
   input  logic [1:0] dphy_hs,          // [1] positive leg, [0] negative leg
   output logic [7:0] deser_out         // one byte per byte_clock, bit 0 oldest
);

   logic       in_se;                   // single-ended lane level
   logic [3:0] rise_sr;                 // bits taken on rising bit_clock
   logic [3:0] fall_sr;                 // bits taken on falling bit_clock
   logic [7:0] deser_word;              // interleaved byte, not yet captured
   logic       rst_sync;                // reset retimed into byte_clock

   // differential receiver, high when p is above n
   assign in_se = dphy_hs[1] & ~dphy_hs[0];

   // ------------------------------------------------------------------------
   // ddr capture, each edge feeds its own 4-bit shifter, newest bit at msb
   // ------------------------------------------------------------------------
   always_ff @(posedge bit_clock) begin
      rise_sr <= {in_se, rise_sr[3:1]};
   end

   always_ff @(negedge bit_clock) begin
      fall_sr <= {in_se, fall_sr[3:1]};
   end

   // rising edge comes first in each byte period
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         deser_word[2*i]   = rise_sr[i];  // even bits
         deser_word[2*i+1] = fall_sr[i];  // odd bits
      end
   end

   // ------------------------------------------------------------------------
   // byte capture, fixed one-period latency
   // ------------------------------------------------------------------------
   always_ff @(posedge byte_clock) begin
      rst_sync <= rst;                  // single flop sync
      if (rst_sync) begin
         deser_out <= '0;
      end else begin
         deser_out <= INVERT ? ~deser_word : deser_word;  // undo pair swap
      end
   end

endmodule

`default_nettype wire

// File: csi_rx_align_byte.sv
`timescale 1ns/1ps
`default_nettype none

// finds the sync byte at any bit offset and emits bytes at that offset
module csi_rx_align_byte
   import csi_pkg::*;
(
   input  logic       byte_clock,
   input  logic       rst,              // sync, active high
   input  logic       enable,           // low clears lock like rst
   input  logic [7:0] deser_out,        // raw byte from phy
   output logic [7:0] aligned_byte,     // byte at locked offset
   output logic       byte_valid,       // aligned_byte holds payload
   output logic       locked            // sync seen, offset fixed
);

   logic [15:0] window;                 // [7:0] older byte, [15:8] newer
   logic [2:0]  offset;                 // locked bit offset into window
   logic [2:0]  hit_offset;             // lowest offset matching sync
   logic        hit;                    // sync found somewhere in window

   // ------------------------------------------------------------------------
   // two-byte window in arrival order
   // ------------------------------------------------------------------------
   always_ff @(posedge byte_clock) begin
      window <= {deser_out, window[15:8]};  // shift by one byte
   end

   // search all eight offsets, walk down so the lowest match wins
   always_comb begin
      hit        = 1'b0;
      hit_offset = '0;
      for (int k = 7; k >= 0; k--) begin
         if (window[k +: 8] == SYNC_BYTE) begin
            hit        = 1'b1;
            hit_offset = 3'(k);
         end
      end
   end

   // ------------------------------------------------------------------------
   // lock state
   // ------------------------------------------------------------------------
   always_ff @(posedge byte_clock) begin
      if (rst || !enable) begin
         locked     <= 1'b0;
         byte_valid <= 1'b0;
         offset     <= '0;
      end else if (!locked) begin
         byte_valid <= 1'b0;            // sync byte itself is swallowed
         if (hit) begin
            locked <= 1'b1;
            offset <= hit_offset;
         end
      end else begin
         byte_valid <= 1'b1;            // one payload byte every cycle once locked
      end
   end

   // registered output, one cycle behind the window that holds the byte
   always_ff @(posedge byte_clock) begin
      aligned_byte <= window[offset +: 8];
   end

endmodule

`default_nettype wire

// File: csi_lane_writer.sv
`timescale 1ns/1ps
`default_nettype none

// packs aligned byte pairs into buffer words for one lane
module csi_lane_writer
   import csi_pkg::*;
#(
   parameter int LANE = 0               // lane index, picks the buffer region
) (
   input  logic       byte_clock,
   input  logic       rst,
   input  logic       enable,           // low restarts the capture
   input  logic [7:0] aligned_byte,
   input  logic       byte_valid,
   input  logic       locked,           // aligner lock, pairing restarts when low
   buf_wr_if.master   wr,               // request towards the arbiter
   output logic       capture_done,     // all LANE_WORDS words written
   output logic       overflow          // sticky, a word was dropped
);

   localparam logic [BUF_AW-1:0] BASE  = BUF_AW'(LANE * LANE_WORDS);
   localparam int                CNT_W = $clog2(LANE_WORDS) + 1;

   logic [7:0]       low_byte;          // first byte of the pair
   logic             half;              // low_byte holds a byte
   logic [CNT_W-1:0] word_cnt;          // words issued so far
   logic             full;              // no more words for this capture
   logic             take;              // accept a byte this cycle
   logic             pair_done;         // second byte of a pair arrives
   logic             stuck;             // pending word still waits for gnt

   assign full      = (word_cnt == CNT_W'(LANE_WORDS));
   assign take      = byte_valid && locked && !full;  // bytes after done ignored
   assign pair_done = take && half;
   assign stuck     = wr.req && !wr.gnt;

   // ------------------------------------------------------------------------
   // control
   // ------------------------------------------------------------------------
   always_ff @(posedge byte_clock) begin
      if (rst || !enable) begin
         half         <= 1'b0;
         word_cnt     <= '0;
         wr.req       <= 1'b0;
         capture_done <= 1'b0;
         overflow     <= 1'b0;
      end else begin
         if (!locked) half <= 1'b0;
         else if (take) half <= !half;  // toggles per accepted byte

         if (wr.req && wr.gnt) wr.req <= 1'b0;  // written this cycle
         if (pair_done) begin
            if (stuck) begin
               overflow <= 1'b1;        // new word dropped
            end else begin
               wr.req   <= 1'b1;        // rises the cycle after the pair
               word_cnt <= word_cnt + 1'b1;
            end
         end

         // last issued word granted
         if (wr.req && wr.gnt && full) capture_done <= 1'b1;
      end
   end

   // ------------------------------------------------------------------------
   // payload, no reset
   // ------------------------------------------------------------------------
   always_ff @(posedge byte_clock) begin
      if (take && !half) low_byte <= aligned_byte;
      if (pair_done && !stuck) begin
         wr.data <= {aligned_byte, low_byte};      // first byte in low half
         wr.addr <= BASE + BUF_AW'(word_cnt);      // region base plus count
      end
   end

endmodule

`default_nettype wire

// File: csi_buf_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// round-robin share of the line buffer write port
module csi_buf_arbiter
   import csi_pkg::*;
(
   input  logic              byte_clock,
   input  logic              rst,
   buf_wr_if.arbiter         lanes [NUM_LANES],  // one per lane writer
   output logic              wr_en,
   output logic [BUF_AW-1:0] wr_addr,
   output buf_word_t         wr_data
);

   localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   logic [NUM_LANES-1:0] req_vec;       // collected requests
   logic [NUM_LANES-1:0] gnt_vec;       // one-hot or zero
   logic [BUF_AW-1:0]    addr_arr [NUM_LANES];
   buf_word_t            data_arr [NUM_LANES];
   logic [PTR_W-1:0]     ptr;           // lane with top priority
   logic [PTR_W-1:0]     sel;           // granted lane

   // flatten the interface array
   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      assign req_vec[i]    = lanes[i].req;
      assign addr_arr[i]   = lanes[i].addr;
      assign data_arr[i]   = lanes[i].data;
      assign lanes[i].gnt  = gnt_vec[i];
   end

   // ------------------------------------------------------------------------
   // grant, combinational from req and pointer
   // ------------------------------------------------------------------------
   always_comb begin
      int idx;
      gnt_vec = '0;
      sel     = '0;
      for (int k = NUM_LANES - 1; k >= 0; k--) begin  // last hit is nearest ptr
         idx = (int'(ptr) + k) % NUM_LANES;
         if (req_vec[idx]) begin
            gnt_vec = '0;
            gnt_vec[idx] = 1'b1;
            sel = PTR_W'(idx);
         end
      end
   end

   // pointer moves just past the lane last granted
   always_ff @(posedge byte_clock) begin
      if (rst) begin
         ptr <= '0;
      end else if (|gnt_vec) begin
         ptr <= PTR_W'((int'(sel) + 1) % NUM_LANES);
      end
   end

   // write port follows the grant in the same cycle
   assign wr_en   = |gnt_vec;
   assign wr_addr = addr_arr[sel];
   assign wr_data = data_arr[sel];

endmodule

`default_nettype wire

// File: csi_line_buf.sv
`timescale 1ns/1ps
`default_nettype none

// line buffer, one write port and one registered read port
module csi_line_buf
   import csi_pkg::*;
(
   input  logic              byte_clock,
   input  logic              wr_en,
   input  logic [BUF_AW-1:0] wr_addr,
   input  buf_word_t         wr_data,
   input  logic [BUF_AW-1:0] rd_addr,
   output buf_word_t         rd_data    // one cycle after rd_addr
);

   localparam int DEPTH = NUM_LANES * LANE_WORDS;  // lane regions back to back

   buf_word_t mem [DEPTH];

   always_ff @(posedge byte_clock) begin
      if (wr_en) mem[wr_addr] <= wr_data;  // granted lane's word
   end

   always_ff @(posedge byte_clock) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// File: csi_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

// two-lane csi receive data path into a shared line buffer
module csi_rx_top
   import csi_pkg::*;
#(
   parameter logic [NUM_LANES-1:0] LANE_INVERT = '0  // per lane pair swap
) (
   input  logic                       bit_clock,
   input  logic                       byte_clock,
   input  logic                       rst,
   input  logic                       enable,
   input  logic [NUM_LANES-1:0][1:0]  dphy_hs,       // [lane][1] p, [lane][0] n
   input  logic [BUF_AW-1:0]          rd_addr,
   output buf_word_t                  rd_data,
   output logic [NUM_LANES-1:0]       capture_done,
   output logic [NUM_LANES-1:0]       overflow
);

   logic              wr_en;
   logic [BUF_AW-1:0] wr_addr;
   buf_word_t         wr_data;

   buf_wr_if wr_if [NUM_LANES] ();      // one write request per lane

   // ------------------------------------------------------------------------
   // per lane phy, aligner and writer
   // ------------------------------------------------------------------------
   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      logic [7:0] deser_out;
      logic [7:0] aligned_byte;
      logic       byte_valid;
      logic       locked;

      csi_rx_phy_dat #(
         .INVERT (LANE_INVERT[i])
      ) u_phy (
         .bit_clock  (bit_clock),
         .byte_clock (byte_clock),
         .rst        (rst),
         .dphy_hs    (dphy_hs[i]),
         .deser_out  (deser_out)
      );

      csi_rx_align_byte u_align (
         .byte_clock   (byte_clock),
         .rst          (rst),
         .enable       (enable),
         .deser_out    (deser_out),
         .aligned_byte (aligned_byte),
         .byte_valid   (byte_valid),
         .locked       (locked)
      );

      csi_lane_writer #(
         .LANE (i)
      ) u_writer (
         .byte_clock   (byte_clock),
         .rst          (rst),
         .enable       (enable),
         .aligned_byte (aligned_byte),
         .byte_valid   (byte_valid),
         .locked       (locked),
         .wr           (wr_if[i]),
         .capture_done (capture_done[i]),
         .overflow     (overflow[i])
      );
   end

   // ------------------------------------------------------------------------
   // shared buffer
   // ------------------------------------------------------------------------
   csi_buf_arbiter u_arbiter (
      .byte_clock (byte_clock),
      .rst        (rst),
      .lanes      (wr_if),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data)
   );

   csi_line_buf u_line_buf (
      .byte_clock (byte_clock),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data)
   );

endmodule

`default_nettype wire

// File: csi_rx_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// request and grant rules bound into the lane writers and the arbiter
module csi_rx_asserts
   import csi_pkg::*;
#(
   parameter int N = 1                  // request lines seen at this point
) (
   input  logic              byte_clock,
   input  logic              rst,
   input  logic              enable,
   input  logic [N-1:0]      req,
   input  logic [N-1:0]      gnt,
   input  logic [BUF_AW-1:0] addr,
   input  buf_word_t         data,
   input  logic              capture_done
);

   // at most one lane owns the write port
   if (N > 1) begin : g_onehot
      a_gnt_onehot : assert property (@(posedge byte_clock) disable iff (rst)
         $onehot0(gnt))
         else $error("gnt not one-hot: %b", gnt);
   end

   // no grant without a request
   a_gnt_req : assert property (@(posedge byte_clock) disable iff (rst)
      (gnt & ~req) == '0)
      else $error("gnt %b without req %b", gnt, req);

   // a single writer keeps its word steady while it waits
   if (N == 1) begin : g_hold
      a_hold : assert property (@(posedge byte_clock) disable iff (rst || !enable)
         (req[0] && !gnt[0]) |=> (req[0] && $stable(addr) && $stable(data)))
         else $error("writer changed addr or data while waiting");
   end

   // done is sticky until the capture is restarted
   if (N == 1) begin : g_done
      a_done_sticky : assert property (@(posedge byte_clock) disable iff (rst)
         (capture_done && enable) |=> (capture_done || !enable))
         else $error("capture_done fell while enable high");
   end

endmodule

bind csi_lane_writer csi_rx_asserts #(.N(1)) u_asserts (
   .byte_clock   (byte_clock),
   .rst          (rst),
   .enable       (enable),
   .req          (wr.req),
   .gnt          (wr.gnt),
   .addr         (wr.addr),
   .data         (wr.data),
   .capture_done (capture_done)
);

bind csi_buf_arbiter csi_rx_asserts #(.N(csi_pkg::NUM_LANES)) u_asserts (
   .byte_clock   (byte_clock),
   .rst          (rst),
   .enable       (1'b1),
   .req          (req_vec),
   .gnt          (gnt_vec),
   .addr         (wr_addr),
   .data         (wr_data),
   .capture_done (1'b0)
);

`default_nettype wire

// File: csi_rx_checker.sv
`timescale 1ns/1ps
`default_nettype none

// watches the read port and status flags and compares against the payload
module csi_rx_checker
   import csi_pkg::*;
(
   input  logic                              byte_clock,
   input  logic                              rst,
   input  logic                              rd_check,  // rd_addr holds a read
   input  logic [BUF_AW-1:0]                 rd_addr,
   input  buf_word_t                         rd_data,
   input  logic [NUM_LANES-1:0]              capture_done,
   input  logic [NUM_LANES-1:0]              overflow,
   input  logic [NUM_LANES-1:0][63:0][7:0]   payload    // bytes as sent
);

   int                   errors = 0;
   int                   reads  = 0;
   logic                 pend   = 1'b0;     // read data due this cycle
   logic [BUF_AW-1:0]    pend_addr;
   logic                 rst_q  = 1'b1;
   logic [NUM_LANES-1:0] ovf_seen = '0;     // one report per lane

   // expected word holds byte 2w of the lane low and byte 2w+1 high
   function automatic buf_word_t expect_word(input logic [BUF_AW-1:0] a);
      int lane;
      int w;
      lane = int'(a) / LANE_WORDS;
      w    = int'(a) % LANE_WORDS;
      return {payload[lane][2*w+1], payload[lane][2*w]};
   endfunction

   // ------------------------------------------------------------------------
   // compare process
   // ------------------------------------------------------------------------
   always @(posedge byte_clock) begin
      rst_q <= rst;
      if (rst_q && !rst) begin          // first cycle out of reset
         if (capture_done !== '0) begin
            $display("FAIL capture_done after reset got=%h exp=%h", capture_done, 2'h0);
            errors++;
         end
         if (overflow !== '0) begin
            $display("FAIL overflow after reset got=%h exp=%h", overflow, 2'h0);
            errors++;
         end
      end
      if (!rst) begin
         for (int l = 0; l < NUM_LANES; l++) begin
            if (overflow[l] && !ovf_seen[l]) begin
               $display("FAIL overflow[%0d] got=%h exp=%h", l, 1'b1, 1'b0);
               errors++;
               ovf_seen[l] <= 1'b1;
            end
         end
      end
      if (pend) begin                   // rd_data is one cycle behind rd_addr
         reads++;
         if (rd_data !== expect_word(pend_addr)) begin
            $display("FAIL rd_data addr=%h got=%h exp=%h",
                     pend_addr, rd_data, expect_word(pend_addr));
            errors++;
         end
      end
      pend      <= rd_check;
      pend_addr <= rd_addr;
   end

   // closing count line with ok set only when every read matched
   task automatic report(input int exp_reads, output logic ok);
      if (reads != exp_reads) begin
         $display("read count wrong, got %0d reads but expected %0d", reads, exp_reads);
         errors++;
      end
      $display("checker: errors=%0d reads=%0d", errors, reads);
      ok = (errors == 0);
   endtask

endmodule

`default_nettype wire

// File: tb_csi_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csi_rx
   import csi_pkg::*;
();

   localparam logic [NUM_LANES-1:0] LANE_INV = 2'b10;  // lane 1 swapped on the board
   localparam int PRE_BITS  = 16;                       // idle zeros before sync
   localparam int CAP_BITS  = PRE_BITS + 7 + 8 + 512 + 16;  // worst case per lane
   localparam int MAX_BITS  = 560;
   localparam int RD_CYCLES = NUM_LANES * LANE_WORDS + 2;
   localparam int LIMIT     = 3 * (2 * CAP_BITS / 8 + 2 * RD_CYCLES);

   logic                            bit_clock  = 1'b1;
   logic                            byte_clock = 1'b0;
   logic                            rst        = 1'b1;
   logic                            enable     = 1'b0;
   logic [1:0]                      dphy0      = 2'b01;  // true zero with p low and n high
   logic [1:0]                      dphy1      = 2'b10;  // inverted zero
   logic [NUM_LANES-1:0][1:0]       dphy_hs;
   logic [BUF_AW-1:0]               rd_addr    = '0;
   logic                            rd_check   = 1'b0;
   buf_word_t                       rd_data;
   logic [NUM_LANES-1:0]            capture_done;
   logic [NUM_LANES-1:0]            overflow;
   logic [NUM_LANES-1:0][63:0][7:0] payload;
   logic [MAX_BITS-1:0]             stream [NUM_LANES];
   int                              len [NUM_LANES];
   logic [15:0]                     lfsr       = 16'd19703;
   int                              cycles     = 0;
   logic                            ok;

   assign dphy_hs = {dphy1, dphy0};

   // ------------------------------------------------------------------------
   // clocks with bit_clock rising together with byte_clock
   // ------------------------------------------------------------------------
   always #5 byte_clock = ~byte_clock;
   always #1.25 bit_clock = ~bit_clock;  // four bit periods per byte period

   csi_rx_top #(
      .LANE_INVERT (LANE_INV)
   ) u_csi_rx_top (
      .bit_clock    (bit_clock),
      .byte_clock   (byte_clock),
      .rst          (rst),
      .enable       (enable),
      .dphy_hs      (dphy_hs),
      .rd_addr      (rd_addr),
      .rd_data      (rd_data),
      .capture_done (capture_done),
      .overflow     (overflow)
   );

   csi_rx_checker u_checker (
      .byte_clock   (byte_clock),
      .rst          (rst),
      .rd_check     (rd_check),
      .rd_addr      (rd_addr),
      .rd_data      (rd_data),
      .capture_done (capture_done),
      .overflow     (overflow),
      .payload      (payload)
   );

   // galois lfsr with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // fills v from the lsb with one lfsr step per bit
   task automatic take_bits(input int n, output logic [7:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = lfsr[0];
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // zeros, random offset, sync, 64 payload bytes, trailing zeros
   task automatic build_streams();
      logic [7:0] v;
      int         idx;
      for (int l = 0; l < NUM_LANES; l++) begin
         stream[l] = '0;
         take_bits(3, v);
         idx = PRE_BITS + int'(v[2:0]);  // leading zeros already in place
         for (int b = 0; b < 8; b++) stream[l][idx+b] = SYNC_BYTE[b];
         idx += 8;
         for (int k = 0; k < 64; k++) begin
            take_bits(8, v);
            payload[l][k] = v;
            for (int b = 0; b < 8; b++) stream[l][idx+b] = v[b];
            idx += 8;
         end
         len[l] = idx + 16;
      end
   endtask

   // one bit per bit_clock edge and complemented where the lane is swapped
   task automatic send_lane(input int l);
      logic v;
      for (int i = 0; i < len[l]; i++) begin
         @(posedge bit_clock or negedge bit_clock);
         v = stream[l][i] ^ LANE_INV[l];
         if (l == 0) dphy0 <= {v, ~v};
         else dphy1 <= {v, ~v};
      end
   endtask

   // one full capture followed by a wait for both lanes
   task automatic run_capture();
      build_streams();
      fork
         send_lane(0);
         send_lane(1);
      join
      while (capture_done != '1) @(posedge byte_clock);
   endtask

   // read back every address while the checker compares a cycle later
   task automatic read_all();
      for (int a = 0; a < NUM_LANES * LANE_WORDS; a++) begin
         @(posedge byte_clock);
         rd_addr  <= BUF_AW'(a);
         rd_check <= 1'b1;
      end
      @(posedge byte_clock);
      rd_check <= 1'b0;
      repeat (2) @(posedge byte_clock);
   endtask

   // ------------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------------
   initial begin
      repeat (2) @(posedge byte_clock);
      rst    <= 1'b0;
      enable <= 1'b1;
      run_capture();
      read_all();
      @(posedge byte_clock);            // restart with fresh offsets and data
      enable <= 1'b0;
      repeat (2) @(posedge byte_clock);
      enable <= 1'b1;
      run_capture();
      read_all();
      u_checker.report(2 * NUM_LANES * LANE_WORDS, ok);
      if (ok) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // run limit from stream length and readback
   always @(posedge byte_clock) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("timeout after %0d byte cycles, capture_done=%b", cycles, capture_done);
         $display("STATUS: FAIL");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: tb.f
csi_pkg.sv
buf_wr_if.sv
csi_rx_phy_dat.sv
csi_rx_align_byte.sv
csi_lane_writer.sv
csi_buf_arbiter.sv
csi_line_buf.sv
csi_rx_top.sv
csi_rx_asserts.sv
csi_rx_checker.sv
tb_csi_rx.sv

// File: Makefile
SRCS := $(shell grep -v '^+' tb.f)

.PHONY: run clean

run: obj_dir/Vtb_csi_rx
	./obj_dir/Vtb_csi_rx | tee sim.log
	grep -q "STATUS: PASS" sim.log

obj_dir/Vtb_csi_rx: tb.f $(SRCS)
	verilator --binary --timing --assert -f tb.f --top-module tb_csi_rx \
		-Mdir obj_dir -o Vtb_csi_rx

clean:
	rm -rf obj_dir sim.log
